//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing -j 0
TOP      = vga_tb
FILELIST = all.f
OBJDIR   = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	./$(OBJDIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi
	@if ! grep -q "TEST RESULT: PASS" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- all.f
vga_pkg.sv
vga_scan_if.sv
vga_mem.sv
vga_timing.sv
vga_pixel_fetch.sv
vga_top.sv
vga_checker.sv
vga_tb.sv

//--- vga_checker.sv
// Frame buffer model, reference scan counters, per-test comparison and result counts
`timescale 1ns/100ps

module vga_checker (
    input  logic                       clock,
    input  logic                       rst_n,
    input  logic                       core_wren,
    input  logic [vga_pkg::addr_w-1:0] core_address,
    input  logic [3:0]                 core_byteena,
    input  logic [31:0]                core_wdata,
    input  logic [31:0]                core_rdata,
    input  logic                       vga_hsync,
    input  logic                       vga_vsync,
    input  logic                       vga_de,
    input  logic                       vga_pixel,
    input  int                         test_id,
    output int                         error_count,
    output int                         failed_tests,
    output logic                       report_done
);
    import vga_pkg::*;

    localparam int last_test = 6;

    // Buffer model plus one flag per byte lane that has ever been written
    logic [31:0] model_mem   [0:mem_words-1];
    logic [3:0]  model_known [0:mem_words-1];

    // Reference scan position and the word taken at the last 32-pixel boundary
    int          h_ref;
    int          v_ref;
    logic [31:0] fetch_word;
    logic [3:0]  fetch_known;

    // Prediction pipeline, bit 0 is stage one and bit 1 the output register
    logic [1:0]  exp_hs;
    logic [1:0]  exp_vs;
    logic [1:0]  exp_de;
    logic [1:0]  exp_pix;
    logic [1:0]  exp_pix_ok;
    // Expected core read word and its defined lanes
    logic [31:0] exp_rdata;
    logic [3:0]  exp_rmask;

    logic seen_reset = 1'b0;
    logic done       = 1'b0;
    int   prev_id    = 0;
    int   test_errs  = 0;
    int   errs_total = 0;
    int   fails      = 0;
    int   checks     = 0;

    assign error_count  = errs_total;
    assign failed_tests = fails;
    assign report_done  = done;

    initial begin
        for (int i = 0; i < mem_words; i++) begin
            model_mem[i]   = '0;
            model_known[i] = '0;
        end
    end

    function automatic string test_name(input int id);
        case (id)
            1:       return "reset_state";
            2:       return "write_readback";
            3:       return "out_of_range";
            4:       return "read_during_write";
            5:       return "sync_blanking";
            6:       return "pixel_data";
            default: return "idle";
        endcase
    endfunction

    // Expand a lane mask to a bit mask
    function automatic logic [31:0] lane_bits(input logic [3:0] lanes);
        logic [31:0] m;
        for (int i = 0; i < 4; i++) begin
            m[i*8 +: 8] = {8{lanes[i]}};
        end
        return m;
    endfunction

    task automatic report_error(input string sig, input logic [31:0] expected,
                                input logic [31:0] actual);
        errs_total++;
        test_errs++;
        // Keep the log readable when something breaks for a whole frame
        if (errs_total <= 20) begin
            $display("** Error [%s] %s at %0t: expected %h, actual %h",
                     test_name(test_id), sig, $time, expected, actual);
        end
    endtask

    // ======================================================================
    // Compare, then predict, then apply this edge's write
    // ======================================================================

    always @(posedge clock) begin
        logic [31:0]       mask;
        logic [addr_w-1:0] waddr;
        logic              active;
        // Outputs seen here were set by the previous edge
        if (seen_reset) begin
            checks++;
            mask = lane_bits(exp_rmask);
            if ((core_rdata & mask) !== (exp_rdata & mask))
                report_error("core_rdata", exp_rdata & mask, core_rdata & mask);
            if (vga_hsync !== exp_hs[1])
                report_error("vga_hsync", 32'(exp_hs[1]), 32'(vga_hsync));
            if (vga_vsync !== exp_vs[1])
                report_error("vga_vsync", 32'(exp_vs[1]), 32'(vga_vsync));
            if (vga_de !== exp_de[1])
                report_error("vga_de", 32'(exp_de[1]), 32'(vga_de));
            if (exp_pix_ok[1] && (vga_pixel !== exp_pix[1]))
                report_error("vga_pixel", 32'(exp_pix[1]), 32'(vga_pixel));
        end
        if (!rst_n) begin
            seen_reset = 1'b1;
            h_ref      = 0;
            v_ref      = 0;
            exp_hs     = 2'b11;
            exp_vs     = 2'b11;
            exp_de     = 2'b00;
            exp_pix    = 2'b00;
            exp_pix_ok = 2'b11;
            exp_rdata  = '0;
            exp_rmask  = 4'hf;
        end else begin
            active = (h_ref < h_active) && (v_ref < v_active);
            // Display port reads the buffer before this edge's write
            if (active && (h_ref[4:0] == 5'd0)) begin
                waddr       = addr_w'(v_ref * words_per_line + h_ref / 32);
                fetch_word  = model_mem[waddr];
                fetch_known = model_known[waddr];
            end
            exp_hs     = {exp_hs[0], !((h_ref >= h_active + h_front) &&
                                       (h_ref <  h_active + h_front + h_sync))};
            exp_vs     = {exp_vs[0], !((v_ref >= v_active + v_front) &&
                                       (v_ref <  v_active + v_front + v_sync))};
            exp_de     = {exp_de[0], active};
            exp_pix    = {exp_pix[0], active && fetch_word[h_ref[4:0]]};
            exp_pix_ok = {exp_pix_ok[0], !active || fetch_known[h_ref[4:3]]};
            // Core read, old data and zero outside the buffer
            if (int'(core_address) < mem_words) begin
                exp_rdata = model_mem[core_address];
                exp_rmask = model_known[core_address];
            end else begin
                exp_rdata = '0;
                exp_rmask = 4'hf;
            end
            h_ref = (h_ref == h_total - 1) ? 0 : h_ref + 1;
            if (h_ref == 0)
                v_ref = (v_ref == v_total - 1) ? 0 : v_ref + 1;
        end
        if (core_wren && (int'(core_address) < mem_words)) begin
            mask = lane_bits(core_byteena);
            model_mem[core_address]   = (model_mem[core_address] & ~mask) | (core_wdata & mask);
            model_known[core_address] = model_known[core_address] | core_byteena;
        end
        // One line per finished test
        if (test_id != prev_id) begin
            if ((prev_id >= 1) && (prev_id <= last_test)) begin
                $display("test %0d %s: %s, %0d errors", prev_id, test_name(prev_id),
                         (test_errs == 0) ? "ok" : "FAILED", test_errs);
                if (test_errs != 0)
                    fails++;
            end
            test_errs = 0;
            prev_id   = test_id;
            if (test_id > last_test) begin
                $display("tests %0d, failed %0d, checked cycles %0d, errors %0d",
                         last_test, fails, checks, errs_total);
                done = 1'b1;
            end
        end
    end

endmodule

//--- vga_mem.sv
// Dual-port byte-enabled frame buffer with registered reads and an address range guard
`timescale 1ns/100ps

module vga_mem (
    input  logic                       clock,
    input  logic                       rst_n,
    // Core port, write and read back
    input  logic                       core_wren,
    input  logic [vga_pkg::addr_w-1:0] core_address,
    input  logic [3:0]                 core_byteena,
    input  logic [31:0]                core_wdata,
    output logic [31:0]                core_rdata,
    // Display port, read only
    input  logic [vga_pkg::addr_w-1:0] disp_address,
    output logic [31:0]                disp_rdata
);
    import vga_pkg::*;

    // ======================================================================
    // Storage
    // ======================================================================

    // One entry per word, four byte lanes each
    // Lane 0 sits in bits 7:0
    logic [3:0][7:0] mem_array [0:mem_words-1];

    // Range guard results
    logic core_in_range;
    logic disp_in_range;
    logic core_wr_ok;

    // Addresses from 9600 up fall outside the buffer
    assign core_in_range = core_address < addr_w'(mem_words);
    assign disp_in_range = disp_address < addr_w'(mem_words);

    // Write strobe only counts inside the buffer
    assign core_wr_ok = core_wren && core_in_range;

    // ======================================================================
    // Byte-enabled write
    // ======================================================================

    always_ff @(posedge clock) begin
        if (core_wr_ok) begin
            // Lanes without an enable keep their old byte
            for (int lane = 0; lane < 4; lane++) begin
                if (core_byteena[lane]) begin
                    mem_array[core_address][lane] <= core_wdata[lane*8 +: 8];
                end
            end
        end
    end

    // ======================================================================
    // Registered reads
    // ======================================================================

    // Both ports sample the array before this edge's write lands
    // So a same-cycle read and write returns the old word
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            core_rdata <= '0;
            disp_rdata <= '0;
        end else begin
            // Out of range reads as zero
            core_rdata <= core_in_range ? mem_array[core_address] : '0;
            disp_rdata <= disp_in_range ? mem_array[disp_address] : '0;
        end
    end

endmodule

//--- vga_pixel_fetch.sv
// Frame buffer address generation, pixel shift register and two-stage sync alignment
`timescale 1ns/100ps

module vga_pixel_fetch (
    input  logic                       clock,
    input  logic                       rst_n,
    vga_scan_if.sink                   scan,
    // Display read port of the frame buffer
    output logic [vga_pkg::addr_w-1:0] disp_address,
    input  logic [31:0]                disp_rdata,
    // Aligned video outputs
    output logic                       vga_hsync,
    output logic                       vga_vsync,
    output logic                       vga_de,
    output logic                       vga_pixel
);
    import vga_pkg::*;

    // ======================================================================
    // Address generation
    // ======================================================================

    // High on the first pixel of each 32-pixel word
    logic              fetch_en;
    // Start of the current line in the buffer
    logic [addr_w-1:0] line_base;
    // Word index within the line, column divided by 32
    logic [addr_w-1:0] word_in_line;

    // Stage one delays
    logic              load_d1;
    logic              active_d1;
    logic              hsync_d1;
    logic              vsync_d1;

    // Pixel path
    logic [31:0]       shift_reg;
    logic              next_bit;

    assign fetch_en     = scan.active && (scan.h_count[4:0] == 5'd0);
    assign line_base    = addr_w'(scan.v_count) * addr_w'(words_per_line);
    assign word_in_line = addr_w'(scan.h_count[h_cnt_w-1:5]);

    // Word v*20 + h/32, memory answers on the next cycle
    assign disp_address = fetch_en ? line_base + word_in_line : '0;

    // ======================================================================
    // Pixel shift register
    // ======================================================================

    // On a load cycle bit 0 of the fresh word goes straight out
    assign next_bit = load_d1 ? disp_rdata[0] : shift_reg[0];

    // Pixel h maps to word bit h mod 32, so shift towards bit 0
    always_ff @(posedge clock) begin
        if (load_d1) begin
            shift_reg <= {1'b0, disp_rdata[31:1]};
        end else begin
            shift_reg <= {1'b0, shift_reg[31:1]};
        end
    end

    // ======================================================================
    // Two-stage alignment
    // ======================================================================

    // Stage one lines up with the memory read latency
    // Stage two is the output register
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            load_d1   <= 1'b0;
            active_d1 <= 1'b0;
            hsync_d1  <= 1'b1;
            vsync_d1  <= 1'b1;
            vga_de    <= 1'b0;
            vga_pixel <= 1'b0;
            vga_hsync <= 1'b1;
            vga_vsync <= 1'b1;
        end else begin
            load_d1   <= fetch_en;
            active_d1 <= scan.active;
            hsync_d1  <= scan.hsync_raw;
            vsync_d1  <= scan.vsync_raw;
            vga_de    <= active_d1;
            // Blank outside the visible area
            vga_pixel <= active_d1 & next_bit;
            vga_hsync <= hsync_d1;
            vga_vsync <= vsync_d1;
        end
    end

endmodule

//--- vga_pkg.sv
// Display timing, frame buffer geometry and address width constants
package vga_pkg;

    // ======================================================================
    // Horizontal timing in pixel clocks
    // ======================================================================

    // Visible pixels per line
    localparam int h_active = 640;
    // Blanking before the sync pulse
    localparam int h_front  = 16;
    // Sync pulse width
    localparam int h_sync   = 96;
    // Blanking after the sync pulse
    localparam int h_back   = 48;
    // Full line length
    localparam int h_total  = 800;

    // ======================================================================
    // Vertical timing in lines
    // ======================================================================

    // Visible lines per frame
    localparam int v_active = 480;
    localparam int v_front  = 10;
    localparam int v_sync   = 2;
    localparam int v_back   = 33;
    // Full frame height
    localparam int v_total  = 525;

    // ======================================================================
    // Frame buffer geometry
    // ======================================================================

    // 640 pixels at one bit each is 80 bytes per line
    localparam int words_per_line = 20;
    // 20 words times 480 lines
    localparam int mem_words      = 9600;
    // Word address width, covers 0 to 16383
    localparam int addr_w         = 14;

    // Scan counter widths, both reach beyond 800 and 525
    localparam int h_cnt_w = 10;
    localparam int v_cnt_w = 10;

endpackage

//--- vga_scan_if.sv
// Scan position, active video and raw sync bundle with source and sink modports
`timescale 1ns/100ps

interface vga_scan_if;
    import vga_pkg::*;

    // Current pixel column within the line
    logic [h_cnt_w-1:0] h_count;
    // Current line within the frame
    logic [v_cnt_w-1:0] v_count;
    // High inside the 640x480 visible region
    logic               active;
    // Active low syncs, not yet aligned to the pixel
    logic               hsync_raw;
    logic               vsync_raw;

    // Timing generator side
    modport source (
        output h_count,
        output v_count,
        output active,
        output hsync_raw,
        output vsync_raw
    );

    // Pixel fetcher side
    modport sink (
        input h_count,
        input v_count,
        input active,
        input hsync_raw,
        input vsync_raw
    );

endinterface

//--- vga_tb.sv
// Testbench top with clock, reset, LFSR stimulus, test sequence, timeout and DUT instance
`timescale 1ns/100ps

module vga_tb;
    import vga_pkg::*;

    // Reset, fill, core accesses, two frames and margin
    localparam int access_cycles  = 2000;
    localparam int timeout_cycles = 3 + mem_words + access_cycles
                                    + 2 * h_total * v_total + 48_397;
    localparam int n_random       = 400;
    localparam int n_outside      = 200;

    logic              clock;
    logic              rst_n;
    logic              core_wren;
    logic [addr_w-1:0] core_address;
    logic [3:0]        core_byteena;
    logic [31:0]       core_wdata;
    logic [31:0]       core_rdata;
    logic              vga_hsync;
    logic              vga_vsync;
    logic              vga_de;
    logic              vga_pixel;

    int          test_id;
    int          error_count;
    int          failed_tests;
    logic        report_done;
    logic [15:0] lfsr;
    int          cycle_count = 0;

    vga_top vga_top_inst (.*);

    vga_checker vga_checker_inst (.*);

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    // Run limit
    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count >= timeout_cycles) begin
            $display("Timeout, run still going after %0d cycles", timeout_cycles);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    // Taps 16, 14, 13 and 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // One LFSR step per bit
    task automatic take_bits(input int n, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            bits = {bits[30:0], lfsr[0]};
        end
    endtask

    // One core cycle, applied on the falling edge
    task automatic drive(input logic wren, input int addr, input logic [3:0] be,
                         input logic [31:0] data);
        @(negedge clock);
        core_wren    = wren;
        core_address = addr_w'(addr);
        core_byteena = be;
        core_wdata   = data;
    endtask

    initial begin
        logic [31:0] r_addr;
        logic [31:0] r_be;
        logic [31:0] r_data;
        logic [31:0] r_wren;
        int          written[$];
        lfsr         = 16'd51;
        rst_n        = 1'b0;
        core_wren    = 1'b0;
        core_address = '0;
        core_byteena = '0;
        core_wdata   = '0;
        test_id      = 1;
        repeat (3) @(posedge clock);
        @(negedge clock);
        rst_n = 1'b1;
        drive(1'b0, 0, 4'h0, '0);

        // Full fill, then byte-enabled writes and readback
        test_id = 2;
        for (int a = 0; a < mem_words; a++) begin
            take_bits(32, r_data);
            drive(1'b1, a, 4'hf, r_data);
        end
        for (int i = 0; i < n_random; i++) begin
            take_bits(14, r_addr);
            take_bits(4, r_be);
            take_bits(32, r_data);
            written.push_back(int'(r_addr % mem_words));
            drive(1'b1, written[i], r_be[3:0], r_data);
        end
        foreach (written[i])
            drive(1'b0, written[i], 4'h0, '0);

        // Outside the buffer, then confirm in-range words kept their value
        test_id = 3;
        for (int i = 0; i < 2 * n_outside; i++) begin
            take_bits(14, r_addr);
            take_bits(32, r_data);
            drive(i < n_outside, mem_words + int'(r_addr % ((1 << addr_w) - mem_words)),
                  4'hf, r_data);
        end
        for (int i = 0; i < 50; i++)
            drive(1'b0, written[i], 4'h0, '0);

        // Same-cycle read and write, then the new word
        test_id = 4;
        for (int i = 0; i < 8; i++) begin
            take_bits(14, r_addr);
            take_bits(4, r_be);
            take_bits(32, r_data);
            drive(1'b1, int'(r_addr % mem_words), r_be[3:0], r_data);
            drive(1'b0, int'(r_addr % mem_words), 4'h0, '0);
        end

        // Rest of frame one up to the end of its vertical sync
        test_id = 5;
        drive(1'b0, 0, 4'h0, '0);
        @(negedge vga_vsync);
        @(posedge vga_vsync);

        // Frame two with random writes until its vertical sync starts
        test_id = 6;
        do begin
            take_bits(1, r_wren);
            take_bits(14, r_addr);
            take_bits(4, r_be);
            take_bits(32, r_data);
            drive(r_wren[0], int'(r_addr % mem_words), r_be[3:0], r_data);
        end while (vga_vsync);

        test_id = 7;
        drive(1'b0, 0, 4'h0, '0);
        wait (report_done);
        @(negedge clock);
        if ((error_count == 0) && (failed_tests == 0)) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- vga_timing.sv
// Horizontal and vertical scan counters with active video and raw sync decode
`timescale 1ns/100ps

module vga_timing (
    input  logic       clock,
    input  logic       rst_n,
    vga_scan_if.source scan
);
    import vga_pkg::*;

    // ======================================================================
    // Scan counters
    // ======================================================================

    logic [h_cnt_w-1:0] h_cnt;
    logic [v_cnt_w-1:0] v_cnt;

    // End of line and end of frame markers
    logic h_last;
    logic v_last;

    // Region decodes
    logic h_visible;
    logic v_visible;
    logic h_in_sync;
    logic v_in_sync;

    assign h_last = h_cnt == h_cnt_w'(h_total - 1);
    assign v_last = v_cnt == v_cnt_w'(v_total - 1);

    // Column counter runs every clock
    // Line counter steps once per line wrap
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else begin
            if (h_last) begin
                h_cnt <= '0;
                if (v_last) begin
                    v_cnt <= '0;
                end else begin
                    v_cnt <= v_cnt + 1'b1;
                end
            end else begin
                h_cnt <= h_cnt + 1'b1;
            end
        end
    end

    // ======================================================================
    // Region and sync decode
    // ======================================================================

    // Visible area starts at column 0 and line 0
    assign h_visible = h_cnt < h_cnt_w'(h_active);
    assign v_visible = v_cnt < v_cnt_w'(v_active);

    // Horizontal pulse covers columns 656 to 751
    assign h_in_sync = (h_cnt >= h_cnt_w'(h_active + h_front)) &&
                       (h_cnt <  h_cnt_w'(h_active + h_front + h_sync));

    // Vertical pulse covers lines 490 and 491
    assign v_in_sync = (v_cnt >= v_cnt_w'(v_active + v_front)) &&
                       (v_cnt <  v_cnt_w'(v_active + v_front + v_sync));

    // ======================================================================
    // Outputs to the fetcher
    // ======================================================================

    assign scan.h_count   = h_cnt;
    assign scan.v_count   = v_cnt;
    assign scan.active    = h_visible && v_visible;

    // Syncs are active low
    assign scan.hsync_raw = ~h_in_sync;
    assign scan.vsync_raw = ~v_in_sync;

endmodule

//--- vga_top.sv
// Display subsystem top with timing generator, pixel fetcher and frame buffer
`timescale 1ns/100ps

module vga_top (
    input  logic                       clock,
    input  logic                       rst_n,
    // Core access to the frame buffer
    input  logic                       core_wren,
    input  logic [vga_pkg::addr_w-1:0] core_address,
    input  logic [3:0]                 core_byteena,
    input  logic [31:0]                core_wdata,
    output logic [31:0]                core_rdata,
    // Video out
    output logic                       vga_hsync,
    output logic                       vga_vsync,
    output logic                       vga_de,
    output logic                       vga_pixel
);
    import vga_pkg::*;

    // Display read port between fetcher and buffer
    logic [addr_w-1:0] disp_address;
    logic [31:0]       disp_rdata;

    // Scan position bundle
    vga_scan_if scan_if ();

    // ======================================================================
    // Instances
    // ======================================================================

    vga_timing vga_timing_inst (
        .clock (clock),
        .rst_n (rst_n),
        .scan  (scan_if.source)
    );

    vga_pixel_fetch vga_pixel_fetch_inst (
        .clock        (clock),
        .rst_n        (rst_n),
        .scan         (scan_if.sink),
        .disp_address (disp_address),
        .disp_rdata   (disp_rdata),
        .vga_hsync    (vga_hsync),
        .vga_vsync    (vga_vsync),
        .vga_de       (vga_de),
        .vga_pixel    (vga_pixel)
    );

    vga_mem vga_mem_inst (
        .clock        (clock),
        .rst_n        (rst_n),
        .core_wren    (core_wren),
        .core_address (core_address),
        .core_byteena (core_byteena),
        .core_wdata   (core_wdata),
        .core_rdata   (core_rdata),
        .disp_address (disp_address),
        .disp_rdata   (disp_rdata)
    );

endmodule
